/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= tb_icache
FILELIST  ?= icache.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* icache.f */
rtl/icache_geom_pkg.sv
rtl/icache_ctrl_pkg.sv
rtl/icache_tag_store.sv
rtl/icache_data_store.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tests/icache_properties.sv
tests/tb_icache.sv

/* rtl/icache_ctrl.sv */
//////////////////////////////////////////////////
// icache controller
// fetch FSM, address register, flush and enable
// handling, line refill request and result mux
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter int unsigned NumWays = icache_geom_pkg::DefaultNumWays,
  parameter int unsigned NumSets = icache_geom_pkg::DefaultNumSets,
  localparam int unsigned IdxWidth = $clog2(NumSets),
  localparam int unsigned TagWidth = icache_geom_pkg::AddrWidth - IdxWidth
                                   - icache_geom_pkg::OffsetWidth
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // fetch side
  input  logic                                    req_i,
  input  logic [icache_geom_pkg::AddrWidth-1:0]   addr_i,
  output logic                                    ready_o,
  output logic                                    valid_o,
  output logic [icache_geom_pkg::FetchWidth-1:0]  data_o,
  input  logic                                    en_i,
  input  logic                                    flush_i,
  // memory side
  output logic                                    mem_req_o,
  output logic [icache_geom_pkg::AddrWidth-1:0]   mem_addr_o,
  input  logic                                    mem_ack_i,
  input  logic                                    mem_rtrn_vld_i,
  input  icache_ctrl_pkg::rtrn_type_e             mem_rtrn_type_i,
  input  logic [icache_geom_pkg::LineWidth-1:0]   mem_rtrn_data_i,
  input  logic [IdxWidth-1:0]                     mem_rtrn_inv_idx_i,
  // stores
  output logic                                    rd_en_o,
  output logic                                    wr_en_o,
  output logic [IdxWidth-1:0]                     index_o,
  output logic [icache_geom_pkg::OffsetWidth-1:0] offset_o,
  output logic [TagWidth-1:0]                     tag_o,
  output logic                                    clr_en_o,
  output logic [IdxWidth-1:0]                     clr_idx_o,
  input  logic [NumWays-1:0]                      hit_vec_i,
  input  logic [NumWays-1:0][icache_geom_pkg::FetchWidth-1:0] way_words_i
);

  localparam int unsigned OffW = icache_geom_pkg::OffsetWidth;
  localparam int unsigned FetW = icache_geom_pkg::FetchWidth;

  icache_ctrl_pkg::ctrl_state_e state_d, state_q;

  logic                 cache_en_d, cache_en_q;
  // flush seen but not yet taken
  logic                 flush_d, flush_q;
  // refill request raised and waiting for its ack
  logic                 hold_d, hold_q;
  // invalidation hit the set under lookup, read it again
  logic                 reread_d, reread_q;
  logic [IdxWidth-1:0]  flush_cnt_d, flush_cnt_q;
  logic                 flush_en, flush_done;
  logic                 inv_en, fill_en, accept, hit;
  logic [icache_geom_pkg::AddrWidth-1:0] addr_q;
  logic [FetW-1:0]      hit_word, fill_word;

  assign inv_en  = mem_rtrn_vld_i && mem_rtrn_type_i == icache_ctrl_pkg::RTRN_INV_REQ;
  assign fill_en = mem_rtrn_vld_i && mem_rtrn_type_i == icache_ctrl_pkg::RTRN_IFILL_ACK;
  assign hit     = cache_en_q && |hit_vec_i;

  //////////////////////////////////////////////////
  // fetch FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    // disabling is immediate, enabling goes through FLUSH
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    hold_d     = 1'b0;
    reread_d   = reread_q;
    flush_en   = 1'b0;
    accept     = 1'b0;
    ready_o    = 1'b0;
    valid_o    = 1'b0;
    mem_req_o  = 1'b0;
    rd_en_o    = 1'b0;
    wr_en_o    = 1'b0;

    unique case (state_q)
      icache_ctrl_pkg::FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d = icache_ctrl_pkg::IDLE;
          flush_d = 1'b0;
        end
      end
      icache_ctrl_pkg::IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d    = icache_ctrl_pkg::FLUSH;
          cache_en_d = en_i;
        end else if (!mem_rtrn_vld_i) begin
          // returns here can only be invalidations
          ready_o = 1'b1;
          if (req_i) begin
            accept  = 1'b1;
            rd_en_o = cache_en_q;
            state_d = icache_ctrl_pkg::READ;
          end
        end
      end
      icache_ctrl_pkg::READ: begin
        if (hold_q) begin
          // request already out, keep it up until the ack
          mem_req_o = 1'b1;
          hold_d    = ~mem_ack_i;
          if (mem_ack_i) state_d = icache_ctrl_pkg::MISS;
        end else if (inv_en) begin
          // lookup result may be stale once this clear lands
          reread_d = 1'b1;
        end else if (reread_q) begin
          rd_en_o  = cache_en_q;
          reread_d = 1'b0;
        end else if (hit) begin
          valid_o = 1'b1;
          state_d = icache_ctrl_pkg::IDLE;
          // stream the next fetch unless a flush waits
          if (!flush_d && !mem_rtrn_vld_i) begin
            ready_o = 1'b1;
            if (req_i) begin
              accept  = 1'b1;
              rd_en_o = 1'b1;
              state_d = icache_ctrl_pkg::READ;
            end
          end
        end else begin
          // miss, or cache disabled
          mem_req_o = 1'b1;
          hold_d    = ~mem_ack_i;
          if (mem_ack_i) state_d = icache_ctrl_pkg::MISS;
        end
      end
      icache_ctrl_pkg::MISS: begin
        if (fill_en) begin
          valid_o = 1'b1;
          // a disabled cache does not allocate
          wr_en_o = cache_en_q;
          state_d = icache_ctrl_pkg::IDLE;
        end
      end
      default: state_d = icache_ctrl_pkg::FLUSH;
    endcase
  end

  //////////////////////////////////////////////////
  // flush counter and clear steering
  //////////////////////////////////////////////////

  assign flush_done  = flush_cnt_q == IdxWidth'(NumSets - 1);
  assign flush_cnt_d = flush_done ? '0 : flush_en ? flush_cnt_q + 1'b1 : flush_cnt_q;

  // flush wins, the invalidated set is cleared anyway
  assign clr_en_o  = flush_en | inv_en;
  assign clr_idx_o = flush_en ? flush_cnt_q : mem_rtrn_inv_idx_i;

  //////////////////////////////////////////////////
  // address and result
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) addr_q <= addr_i;
  end

  // lookup uses the incoming address, everything later the held one
  assign index_o    = accept ? addr_i[OffW +: IdxWidth] : addr_q[OffW +: IdxWidth];
  assign offset_o   = accept ? addr_i[OffW-1:0] : addr_q[OffW-1:0];
  assign tag_o      = addr_q[icache_geom_pkg::AddrWidth-1 -: TagWidth];
  assign mem_addr_o = {addr_q[icache_geom_pkg::AddrWidth-1:OffW], {OffW{1'b0}}};

  // hit_vec is one-hot on a hit
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (hit_vec_i[w]) hit_word = hit_word | way_words_i[w];
    end
  end

  assign fill_word = mem_rtrn_data_i[addr_q[OffW-1:icache_geom_pkg::ByteSelWidth]*FetW +: FetW];
  assign data_o    = (state_q == icache_ctrl_pkg::MISS) ? fill_word : hit_word;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= icache_ctrl_pkg::FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      hold_q      <= 1'b0;
      reread_q    <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      hold_q      <= hold_d;
      reread_q    <= reread_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/icache_ctrl_pkg.sv */
//////////////////////////////////////////////////
// instruction cache control encodings
// controller states and memory return types
//////////////////////////////////////////////////

`default_nettype none

package icache_ctrl_pkg;

  // FLUSH clears all valid bits, one set per cycle
  // IDLE waits for a fetch
  // READ makes the hit decision or requests a refill
  // MISS waits for the line to come back
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

  // both types share the one return channel
  typedef enum logic {
    RTRN_IFILL_ACK,
    RTRN_INV_REQ
  } rtrn_type_e;

endpackage

`default_nettype wire

/* rtl/icache_data_store.sv */
//////////////////////////////////////////////////
// icache data store
// per-way line arrays, one word per way selected
// by the offset registered with the read
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_data_store #(
  parameter int unsigned NumWays = icache_geom_pkg::DefaultNumWays,
  parameter int unsigned NumSets = icache_geom_pkg::DefaultNumSets,
  localparam int unsigned IdxWidth = $clog2(NumSets),
  localparam int unsigned WayWidth = $clog2(NumWays)
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  rd_en_i,
  input  logic                                  wr_en_i,
  input  logic [WayWidth-1:0]                   wr_way_i,
  input  logic [IdxWidth-1:0]                   index_i,
  input  logic [icache_geom_pkg::OffsetWidth-1:0] offset_i,
  input  logic [icache_geom_pkg::LineWidth-1:0]   line_i,
  output logic [NumWays-1:0][icache_geom_pkg::FetchWidth-1:0] way_words_o
);

  logic [icache_geom_pkg::LineWidth-1:0]    line_mem [NumWays][NumSets];
  logic [icache_geom_pkg::LineWidth-1:0]    rd_line_q [NumWays];
  logic [icache_geom_pkg::WordSelWidth-1:0] word_q;

  // refill writes the whole line into the victim way
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      line_mem[wr_way_i][index_i] <= line_i;
    end
    if (rd_en_i) begin
      for (int w = 0; w < NumWays; w++) begin
        rd_line_q[w] <= line_mem[w][index_i];
      end
    end
  end

  // word index follows the read, byte bits are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q <= '0;
    end else if (rd_en_i) begin
      word_q <= offset_i[icache_geom_pkg::OffsetWidth-1:icache_geom_pkg::ByteSelWidth];
    end
  end

  for (genvar w = 0; w < NumWays; w++) begin : gen_word_sel
    assign way_words_o[w] =
      rd_line_q[w][word_q*icache_geom_pkg::FetchWidth +: icache_geom_pkg::FetchWidth];
  end

endmodule

`default_nettype wire

/* rtl/icache_geom_pkg.sv */
//////////////////////////////////////////////////
// instruction cache geometry
// address, fetch and line widths, the default way
// and set counts, and the replacement LFSR seed
//////////////////////////////////////////////////

`default_nettype none

package icache_geom_pkg;

  // physical fetch address
  localparam int unsigned AddrWidth   = 32;
  // one aligned instruction word
  localparam int unsigned FetchWidth  = 32;
  // one cache line, returned in a single beat
  localparam int unsigned LineWidth   = 128;
  // byte offset inside a line
  localparam int unsigned OffsetWidth = 4;

  // word select and byte select parts of the offset
  localparam int unsigned WordSelWidth = $clog2(LineWidth / FetchWidth);
  localparam int unsigned ByteSelWidth = OffsetWidth - WordSelWidth;

  localparam int unsigned DefaultNumWays = 4;
  localparam int unsigned DefaultNumSets = 64;

  // reset value of the replacement LFSR, must be non-zero
  localparam logic [7:0] LfsrSeed = 8'hA5;

endpackage

`default_nettype wire

/* rtl/icache_tag_store.sv */
//////////////////////////////////////////////////
// icache tag store
// per-way tag and valid arrays, tag compare,
// set clear and victim way selection
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_tag_store #(
  parameter int unsigned NumWays = icache_geom_pkg::DefaultNumWays,
  parameter int unsigned NumSets = icache_geom_pkg::DefaultNumSets,
  localparam int unsigned IdxWidth = $clog2(NumSets),
  localparam int unsigned TagWidth = icache_geom_pkg::AddrWidth - IdxWidth
                                   - icache_geom_pkg::OffsetWidth,
  localparam int unsigned WayWidth = $clog2(NumWays)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rd_en_i,
  input  logic                wr_en_i,
  input  logic [IdxWidth-1:0] index_i,
  input  logic [TagWidth-1:0] tag_i,
  input  logic                clr_en_i,
  input  logic [IdxWidth-1:0] clr_idx_i,
  output logic [NumWays-1:0]  hit_vec_o,
  output logic [WayWidth-1:0] victim_way_o
);

  logic [TagWidth-1:0] tag_mem [NumWays][NumSets];
  logic [NumWays-1:0]  vld_q [NumSets];

  // read side, one cycle after rd_en_i
  logic [TagWidth-1:0] rd_tag_q [NumWays];
  logic [NumWays-1:0]  rd_vld_q;

  // replacement
  logic [7:0]          lfsr_q;
  logic [WayWidth-1:0] inv_way;
  logic                all_valid;

  //////////////////////////////////////////////////
  // valid bits
  //////////////////////////////////////////////////

  // clears come from the flush counter or an invalidation and
  // never share a cycle with a refill write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NumSets; s++) begin
        vld_q[s] <= '0;
      end
      rd_vld_q <= '0;
    end else begin
      if (clr_en_i) begin
        vld_q[clr_idx_i] <= '0;
      end else if (wr_en_i) begin
        vld_q[index_i][victim_way_o] <= 1'b1;
      end
      if (rd_en_i) begin
        rd_vld_q <= vld_q[index_i];
      end
    end
  end

  //////////////////////////////////////////////////
  // tag array
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (wr_en_i && victim_way_o == WayWidth'(w)) begin
        tag_mem[w][index_i] <= tag_i;
      end
      if (rd_en_i) begin
        rd_tag_q[w] <= tag_mem[w][index_i];
      end
    end
  end

  // tag_i is already the registered fetch tag
  for (genvar w = 0; w < NumWays; w++) begin : gen_cmp
    assign hit_vec_o[w] = rd_vld_q[w] && (rd_tag_q[w] == tag_i);
  end

  //////////////////////////////////////////////////
  // victim selection
  //////////////////////////////////////////////////

  // lowest invalid way of the set that was read last
  always_comb begin
    inv_way   = '0;
    all_valid = 1'b1;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!rd_vld_q[w]) begin
        inv_way   = WayWidth'(w);
        all_valid = 1'b0;
      end
    end
  end

  // 8-bit fibonacci lfsr, taps 8 6 5 4
  // advances only when a full set gets a new line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= icache_geom_pkg::LfsrSeed;
    end else if (wr_en_i && all_valid) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  assign victim_way_o = all_valid ? lfsr_q[WayWidth-1:0] : inv_way;

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
//////////////////////////////////////////////////
// set-associative instruction cache, top level
// controller beside the tag and data stores
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int unsigned NumWays = icache_geom_pkg::DefaultNumWays,
  parameter int unsigned NumSets = icache_geom_pkg::DefaultNumSets,
  localparam int unsigned IdxWidth = $clog2(NumSets)
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // fetch and control
  input  logic                                   req_i,
  input  logic [icache_geom_pkg::AddrWidth-1:0]  addr_i,
  input  logic                                   en_i,
  input  logic                                   flush_i,
  output logic                                   ready_o,
  output logic                                   valid_o,
  output logic [icache_geom_pkg::FetchWidth-1:0] data_o,
  // memory
  output logic                                   mem_req_o,
  output logic [icache_geom_pkg::AddrWidth-1:0]  mem_addr_o,
  input  logic                                   mem_ack_i,
  input  logic                                   mem_rtrn_vld_i,
  input  icache_ctrl_pkg::rtrn_type_e            mem_rtrn_type_i,
  input  logic [icache_geom_pkg::LineWidth-1:0]  mem_rtrn_data_i,
  input  logic [IdxWidth-1:0]                    mem_rtrn_inv_idx_i
);

  localparam int unsigned TagWidth = icache_geom_pkg::AddrWidth - IdxWidth
                                   - icache_geom_pkg::OffsetWidth;
  localparam int unsigned WayWidth = $clog2(NumWays);

  logic                                    rd_en, wr_en, clr_en;
  logic [IdxWidth-1:0]                     index, clr_idx;
  logic [icache_geom_pkg::OffsetWidth-1:0] offset;
  logic [TagWidth-1:0]                     tag;
  logic [NumWays-1:0]                      hit_vec;
  logic [WayWidth-1:0]                     victim_way;
  logic [NumWays-1:0][icache_geom_pkg::FetchWidth-1:0] way_words;

  icache_ctrl #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) u_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_i              (req_i),
    .addr_i             (addr_i),
    .ready_o            (ready_o),
    .valid_o            (valid_o),
    .data_o             (data_o),
    .en_i               (en_i),
    .flush_i            (flush_i),
    .mem_req_o          (mem_req_o),
    .mem_addr_o         (mem_addr_o),
    .mem_ack_i          (mem_ack_i),
    .mem_rtrn_vld_i     (mem_rtrn_vld_i),
    .mem_rtrn_type_i    (mem_rtrn_type_i),
    .mem_rtrn_data_i    (mem_rtrn_data_i),
    .mem_rtrn_inv_idx_i (mem_rtrn_inv_idx_i),
    .rd_en_o            (rd_en),
    .wr_en_o            (wr_en),
    .index_o            (index),
    .offset_o           (offset),
    .tag_o              (tag),
    .clr_en_o           (clr_en),
    .clr_idx_o          (clr_idx),
    .hit_vec_i          (hit_vec),
    .way_words_i        (way_words)
  );

  icache_tag_store #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) u_tag_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_en_i      (rd_en),
    .wr_en_i      (wr_en),
    .index_i      (index),
    .tag_i        (tag),
    .clr_en_i     (clr_en),
    .clr_idx_i    (clr_idx),
    .hit_vec_o    (hit_vec),
    .victim_way_o (victim_way)
  );

  // refill line goes straight from the return channel
  icache_data_store #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) u_data_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_en_i     (rd_en),
    .wr_en_i     (wr_en),
    .wr_way_i    (victim_way),
    .index_i     (index),
    .offset_i    (offset),
    .line_i      (mem_rtrn_data_i),
    .way_words_o (way_words)
  );

endmodule

`default_nettype wire

/* tests/icache_properties.sv */
//////////////////////////////////////////////////
// icache protocol properties
// bound into the controller, memory request and
// fetch handshake timing
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_properties (
  input wire        clk_i,
  input wire        rst_ni,
  input wire        ready_o,
  input wire        valid_o,
  input wire        mem_req_o,
  input wire [31:0] mem_addr_o,
  input wire        mem_ack_i,
  input wire        mem_rtrn_vld_i
);

  int fail_count = 0;

  // request stays up with the same line address until acked
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
    else begin
      $error("mem_req_o dropped or mem_addr_o moved before mem_ack_i");
      fail_count++;
    end

  // no fetch accepted while a return is consumed
  no_ready_on_rtrn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rtrn_vld_i |-> !ready_o)
    else begin
      $error("ready_o high during a memory return");
      fail_count++;
    end

  valid_not_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(valid_o && mem_req_o))
    else begin
      $error("valid_o and mem_req_o high together");
      fail_count++;
    end

endmodule

bind icache_ctrl icache_properties u_properties (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .ready_o        (ready_o),
  .valid_o        (valid_o),
  .mem_req_o      (mem_req_o),
  .mem_addr_o     (mem_addr_o),
  .mem_ack_i      (mem_ack_i),
  .mem_rtrn_vld_i (mem_rtrn_vld_i)
);

`default_nettype wire

/* tests/tb_icache.sv */
//////////////////////////////////////////////////
// icache testbench
// drives fetches against a small 2-way 8-set cache,
// models the memory side and checks every result
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int NumWays      = 2;
  localparam int NumSets      = 8;
  localparam int WaitTimeout  = 200;
  localparam int FetchTimeout = 100;
  // model data is the byte address xor this key
  localparam logic [31:0] DataKey = 32'h5A3C_96E1;

  logic         clk_i;
  logic         rst_ni;
  logic         req_i;
  logic [31:0]  addr_i;
  logic         en_i;
  logic         flush_i;
  logic         ready_o;
  logic         valid_o;
  logic [31:0]  data_o;
  logic         mem_req_o;
  logic [31:0]  mem_addr_o;
  logic         mem_ack_i;
  logic         mem_rtrn_vld_i;
  icache_ctrl_pkg::rtrn_type_e mem_rtrn_type_i;
  logic [127:0] mem_rtrn_data_i;
  logic [2:0]   mem_rtrn_inv_idx_i;

  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;
  string       test_name;
  logic [31:0] rnd_q;

  icache_top #(
    .NumWays (NumWays),
    .NumSets (NumSets)
  ) u_dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_i              (req_i),
    .addr_i             (addr_i),
    .en_i               (en_i),
    .flush_i            (flush_i),
    .ready_o            (ready_o),
    .valid_o            (valid_o),
    .data_o             (data_o),
    .mem_req_o          (mem_req_o),
    .mem_addr_o         (mem_addr_o),
    .mem_ack_i          (mem_ack_i),
    .mem_rtrn_vld_i     (mem_rtrn_vld_i),
    .mem_rtrn_type_i    (mem_rtrn_type_i),
    .mem_rtrn_data_i    (mem_rtrn_data_i),
    .mem_rtrn_inv_idx_i (mem_rtrn_inv_idx_i)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    rnd_q = rnd_q * 32'd1664525 + 32'd1013904223;
    return rnd_q >> 16;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ DataKey;
  endfunction

  function automatic logic [127:0] model_line(input logic [31:0] line_addr);
    logic [127:0] line;
    for (int k = 0; k < 4; k++) begin
      line[k*32 +: 32] = model_word(line_addr + 32'(4 * k));
    end
    return line;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    errors_at_start = errors;
    tests_run++;
    test_name = name;
  endtask

  task automatic finish_test();
    if (errors != errors_at_start) tests_failed++;
    $display("test %0d %s: done with %0d errors", tests_run, test_name,
             errors - errors_at_start);
  endtask

  // returns at a falling edge with ready_o high
  task automatic wait_ready(output int n);
    n = 0;
    @(negedge clk_i);
    while (!ready_o && n < WaitTimeout) begin
      @(negedge clk_i);
      n++;
    end
    assert (ready_o) else begin
      $display("timeout: ready_o never came back high");
      errors++;
    end
  endtask

  task automatic send_invalidation(input logic [2:0] idx);
    @(posedge clk_i);
    mem_rtrn_vld_i     <= 1'b1;
    mem_rtrn_type_i    <= icache_ctrl_pkg::RTRN_INV_REQ;
    mem_rtrn_inv_idx_i <= idx;
    @(posedge clk_i);
    mem_rtrn_vld_i     <= 1'b0;
    mem_rtrn_type_i    <= icache_ctrl_pkg::RTRN_IFILL_ACK;
  endtask

  // one fetch with the memory model inline
  // expect_hit is 1 for a hit, 0 for a miss, -1 for either
  task automatic fetch(input logic [31:0] addr, input int expect_hit);
    int          n;
    int          cycles;
    int          ack_wait;
    int          rtrn_wait;
    int          phase;
    bit          got;
    bit          saw_req;
    bit          req_now;
    logic [31:0] line_addr;
    line_addr = {addr[31:4], 4'h0};
    cycles    = 0;
    got       = 0;
    saw_req   = 0;
    phase     = 0;
    rtrn_wait = 0;
    ack_wait  = int'(lcg_next() % 4);
    wait_ready(n);
    @(posedge clk_i);
    req_i  <= 1'b1;
    addr_i <= addr;
    @(negedge clk_i);
    assert (ready_o) else begin
      $display("fetch of %h was not accepted", addr);
      errors++;
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    while (!got && cycles < FetchTimeout) begin
      @(negedge clk_i);
      cycles++;
      req_now = mem_req_o;
      if (req_now) begin
        saw_req = 1;
        check_value("mem_addr_o", mem_addr_o, line_addr);
      end
      if (expect_hit == 0 && cycles == 1) begin
        assert (req_now) else begin
          $display("miss on %h did not raise mem_req_o after one cycle", addr);
          errors++;
        end
      end
      if (valid_o) begin
        got = 1;
        check_value("data_o", data_o, model_word(addr));
        if (expect_hit == 1) begin
          assert (cycles == 1 && !saw_req) else begin
            $display("fetch of %h should have hit but took %0d cycles", addr, cycles);
            errors++;
          end
        end
      end
      @(posedge clk_i);
      mem_ack_i      <= 1'b0;
      mem_rtrn_vld_i <= 1'b0;
      // phase 0 waits to ack, phase 1 counts down to the line return
      if (!got && phase == 0 && req_now) begin
        if (ack_wait == 0) begin
          mem_ack_i <= 1'b1;
          rtrn_wait = 2 + int'(lcg_next() % 4);
          phase     = 1;
        end else begin
          ack_wait--;
        end
      end else if (!got && phase == 1) begin
        if (rtrn_wait > 0) begin
          rtrn_wait--;
        end else begin
          mem_rtrn_vld_i  <= 1'b1;
          mem_rtrn_type_i <= icache_ctrl_pkg::RTRN_IFILL_ACK;
          mem_rtrn_data_i <= model_line(line_addr);
          phase = 2;
        end
      end
    end
    assert (got) else begin
      $display("timeout: fetch of %h never returned valid_o", addr);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int          n;
    int          pick;
    int          word;
    logic [31:0] a;
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    req_i              = 1'b0;
    addr_i             = '0;
    en_i               = 1'b0;
    flush_i            = 1'b0;
    mem_ack_i          = 1'b0;
    mem_rtrn_vld_i     = 1'b0;
    mem_rtrn_type_i    = icache_ctrl_pkg::RTRN_IFILL_ACK;
    mem_rtrn_data_i    = '0;
    mem_rtrn_inv_idx_i = '0;
    errors             = 0;
    tests_run          = 0;
    tests_failed       = 0;
    test_name          = "";
    rnd_q              = 32'h79d7_0249;

    start_test("reset flush and enable clear");
    repeat (2) begin
      @(negedge clk_i);
      check_value("ready_o", 32'(ready_o), 32'h0);
      check_value("mem_req_o", 32'(mem_req_o), 32'h0);
      check_value("valid_o", 32'(valid_o), 32'h0);
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    wait_ready(n);
    // one set cleared per cycle
    assert (n == NumSets) else begin
      $display("reset flush held ready_o low for %0d cycles, not %0d", n, NumSets);
      errors++;
    end
    @(posedge clk_i);
    en_i <= 1'b1;
    @(negedge clk_i);
    check_value("ready_o", 32'(ready_o), 32'h0);
    wait_ready(n);
    assert (n == NumSets) else begin
      $display("enable clear held ready_o low for %0d cycles, not %0d", n, NumSets);
      errors++;
    end
    finish_test();

    start_test("first fetch misses and refills");
    fetch(32'h0000_1238, 0);
    finish_test();

    start_test("fetches in a filled line hit");
    fetch(32'h0000_123C, 1);
    fetch(32'h0000_1230, 1);
    finish_test();

    start_test("disabled cache goes to memory");
    @(posedge clk_i);
    en_i <= 1'b0;
    fetch(32'h0000_1238, 0);
    fetch(32'h0000_1238, 0);
    fetch(32'h0000_2244, 0);
    fetch(32'h0000_2244, 0);
    @(posedge clk_i);
    en_i <= 1'b1;
    finish_test();

    start_test("invalidation and flush");
    fetch(32'h0000_1238, 0);
    fetch(32'h0000_1238, 1);
    send_invalidation(3'd3);
    fetch(32'h0000_1238, 0);
    fetch(32'h0000_1230, 1);
    fetch(32'h0000_2244, 0);
    fetch(32'h0000_3300, 0);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    fetch(32'h0000_1238, 0);
    fetch(32'h0000_2244, 0);
    fetch(32'h0000_3300, 0);
    finish_test();

    start_test("three tags in one set");
    for (int i = 0; i < 24; i++) begin
      pick = int'(lcg_next() % 3);
      word = int'(lcg_next() % 4);
      a    = 32'h0000_4050 + 32'(pick * 128);
      fetch(a + 32'(word * 4), -1);
      fetch(a + 32'(((word + 1) % 4) * 4), 1);
    end
    finish_test();

    $display("tests: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
             tests_run, tests_failed, errors, u_dut.u_ctrl.u_properties.fail_count);
    if (errors == 0 && u_dut.u_ctrl.u_properties.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
